// File: src.f
verilog/radio_pkg.sv
verilog/timekeeper.sv
verilog/radio_channel.sv
verilog/resp_arbiter.sv
verilog/radio_block.sv
bench/radio_block_tb.sv

// File: Makefile
# Verilator build and run of the radio block testbench

VERILATOR ?= verilator
TOP       ?= radio_block_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/radio_block_tb.sv
// Testbench for the radio block with three channels
// Reference model of registers and time, response packet checks
`timescale 1ns/1ps

module radio_block_tb;

  localparam int NUM_RADIOS = 3;
  localparam int SW         = radio_pkg::SAMPLE_W;
  localparam int RW         = radio_pkg::RESP_W;
  localparam int TIMEOUT    = 500;

  logic                       clk = 1'b0;
  logic                       i_reset;
  logic                       i_set_stb;
  logic [2:0]                 i_set_radio;
  logic [7:0]                 i_set_addr;
  logic [31:0]                i_set_data;
  logic [NUM_RADIOS*SW-1:0]   i_rx;
  logic                       i_rx_stb;
  logic                       i_pps;
  logic                       i_resp_tready;
  logic [NUM_RADIOS*SW-1:0]   o_tx;
  logic [RW-1:0]              o_resp_tdata;
  logic                       o_resp_tlast;
  logic                       o_resp_tvalid;
  logic                       bp_enable = 1'b0;

  // Reference model state
  logic [radio_pkg::TIME_W-1:0] ref_time;
  logic [radio_pkg::TIME_W-1:0] ref_lastpps;
  logic [31:0]                  ref_hi;
  logic [31:0]                  ref_lo;
  logic                         ref_armed;
  logic [SW-1:0]                ref_tx [NUM_RADIOS];
  logic [SW-1:0]                ref_user [NUM_RADIOS];
  logic [SW-1:0]                ref_rx [NUM_RADIOS];
  logic [15:0]                  ref_seq [NUM_RADIOS];

  // Accepted output beats
  logic [RW-1:0] beat_data [$];
  logic          beat_last [$];

  radio_block #(
    .NUM_RADIOS (NUM_RADIOS)
  ) i_dut (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_set_stb     (i_set_stb),
    .i_set_radio   (i_set_radio),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .i_rx          (i_rx),
    .i_rx_stb      (i_rx_stb),
    .o_tx          (o_tx),
    .i_pps         (i_pps),
    .o_resp_tdata  (o_resp_tdata),
    .o_resp_tlast  (o_resp_tlast),
    .o_resp_tvalid (o_resp_tvalid),
    .i_resp_tready (i_resp_tready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (!i_reset && o_resp_tvalid && i_resp_tready) begin
      beat_data.push_back(o_resp_tdata);
      beat_last.push_back(o_resp_tlast);
    end
  end

  // Random back-pressure while enabled
  initial begin
    i_resp_tready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      i_resp_tready = bp_enable ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_header(input radio_pkg::resp_word_t got, input radio_pkg::resp_word_t exp);
    if (got.data !== exp.data) begin
      fail_stop($sformatf("MISMATCH o_resp_tdata header got %h exp %h", got.data, exp.data));
    end
  endtask

  task automatic check_data(input logic [RW-1:0] got, input logic [RW-1:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH o_resp_tdata data got %h exp %h", got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH o_resp_tlast got %h exp %h", got, exp));
    end
  endtask

  task automatic check_tx(input int lane, input logic [SW-1:0] got, input logic [SW-1:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH o_tx[%0d] got %h exp %h", lane, got, exp));
    end
  endtask

  task automatic check_all_tx();
    for (int l = 0; l < NUM_RADIOS; l++) begin
      check_tx(l, o_tx[l*SW +: SW], ref_tx[l]);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [RW-1:0] expected_readback(input int radio, input logic [7:0] sel);
    case (sel)
      radio_pkg::RB_TIME:         return ref_time;
      radio_pkg::RB_TIME_LASTPPS: return ref_lastpps;
      radio_pkg::RB_RX_SAMPLE:    return {32'd0, ref_rx[radio]};
      radio_pkg::RB_USER:         return {32'd0, ref_user[radio]};
      default:                    return '0;
    endcase
  endfunction

  function automatic radio_pkg::resp_word_t make_header(input int radio, input logic [7:0] sel);
    radio_pkg::resp_word_t h;
    h.data         = '0;
    h.hdr.seqnum   = ref_seq[radio];
    h.hdr.radio    = 8'(radio);
    h.hdr.rb_sel   = sel;
    h.hdr.time_lo  = ref_time[31:0];
    return h;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // One settings bus strobe that the model follows
  task automatic set_write(input int radio, input logic [7:0] addr, input logic [31:0] data);
    i_set_stb   = 1'b1;
    i_set_radio = 3'(radio);
    i_set_addr  = addr;
    i_set_data  = data;
    tick();
    i_set_stb = 1'b0;
    case (addr)
      radio_pkg::SR_TIME_HI: ref_hi = data;
      radio_pkg::SR_TIME_LO: ref_lo = data;
      radio_pkg::SR_TIME_CTRL: begin
        if (data[radio_pkg::TIME_CTRL_NOW]) begin
          ref_time = {ref_hi, ref_lo};
        end
        ref_armed = data[radio_pkg::TIME_CTRL_PPS];
      end
      radio_pkg::SR_TX_WORD: ref_tx[radio] = data;
      radio_pkg::SR_USER:    ref_user[radio] = data;
      default: ;
    endcase
  endtask

  task automatic rx_burst(input int n);
    for (int k = 0; k < n; k++) begin
      for (int l = 0; l < NUM_RADIOS; l++) begin
        i_rx[l*SW +: SW] = $urandom;
      end
      i_rx_stb = 1'b1;
      tick();
      i_rx_stb = 1'b0;
      ref_time = ref_time + 64'd1;
      for (int l = 0; l < NUM_RADIOS; l++) begin
        ref_rx[l] = i_rx[l*SW +: SW];
      end
      if ($urandom_range(0, 1) == 1) begin
        tick();
      end
    end
  endtask

  task automatic pulse_pps();
    i_pps = 1'b1;
    tick();
    ref_lastpps = ref_time;
    if (ref_armed) begin
      ref_time  = {ref_hi, ref_lo};
      ref_armed = 1'b0;
    end
    i_pps = 1'b0;
    tick();
  endtask

  task automatic wait_beats(input int n);
    int cnt;
    cnt = 0;
    while (beat_data.size() < n) begin
      if (cnt >= TIMEOUT) begin
        fail_stop("Timeout while waiting for response beats");
      end
      tick();
      cnt++;
    end
  endtask

  task automatic take_packet(output radio_pkg::resp_word_t hdr, output logic [RW-1:0] data);
    wait_beats(2);
    hdr.data = beat_data.pop_front();
    check_last(beat_last.pop_front(), 1'b0);
    data = beat_data.pop_front();
    check_last(beat_last.pop_front(), 1'b1);
  endtask

  task automatic readback(input int radio, input logic [7:0] sel);
    radio_pkg::resp_word_t exp_hdr;
    radio_pkg::resp_word_t got_hdr;
    logic [RW-1:0]         exp_data;
    logic [RW-1:0]         got_data;
    exp_hdr        = make_header(radio, sel);
    exp_data       = expected_readback(radio, sel);
    ref_seq[radio] = ref_seq[radio] + 16'd1;
    set_write(radio, radio_pkg::SR_RB_REQ, {24'd0, sel});
    take_packet(got_hdr, got_data);
    check_header(got_hdr, exp_hdr);
    check_data(got_data, exp_data);
  endtask

  // All radios requested back to back under random back-pressure
  task automatic arbitration_test();
    radio_pkg::resp_word_t exp_hdr [NUM_RADIOS];
    logic [RW-1:0]         exp_data [NUM_RADIOS];
    logic                  seen [NUM_RADIOS];
    radio_pkg::resp_word_t got_hdr;
    logic [RW-1:0]         got_data;
    int                    r;
    bp_enable = 1'b1;
    for (int i = 0; i < NUM_RADIOS; i++) begin
      seen[i]     = 1'b0;
      exp_hdr[i]  = make_header(i, 8'(i));
      exp_data[i] = expected_readback(i, 8'(i));
      ref_seq[i]  = ref_seq[i] + 16'd1;
      set_write(i, radio_pkg::SR_RB_REQ, 32'(i));
    end
    for (int p = 0; p < NUM_RADIOS; p++) begin
      take_packet(got_hdr, got_data);
      r = int'(got_hdr.hdr.radio);
      if (r >= NUM_RADIOS || seen[r]) begin
        fail_stop("Response packet with an unknown or repeated radio number");
      end
      seen[r] = 1'b1;
      check_header(got_hdr, exp_hdr[r]);
      check_data(got_data, exp_data[r]);
    end
    bp_enable = 1'b0;
    repeat (10) tick();
    if (beat_data.size() != 0) begin
      fail_stop("Extra response beats after the last packet");
    end
  endtask

  initial begin
    void'($urandom(32'h6b8f30c4));
    i_reset     = 1'b1;
    i_set_stb   = 1'b0;
    i_set_radio = '0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_rx        = '0;
    i_rx_stb    = 1'b0;
    i_pps       = 1'b0;
    ref_time    = '0;
    ref_lastpps = '0;
    ref_hi      = '0;
    ref_lo      = '0;
    ref_armed   = 1'b0;
    for (int i = 0; i < NUM_RADIOS; i++) begin
      ref_tx[i]   = '0;
      ref_user[i] = '0;
      ref_rx[i]   = '0;
      ref_seq[i]  = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    i_reset = 1'b0;
    check_all_tx();

    // Register writes
    for (int r = 0; r < NUM_RADIOS; r++) begin
      repeat (3) begin
        set_write(r, radio_pkg::SR_TX_WORD, $urandom);
        check_all_tx();
        set_write(r, radio_pkg::SR_USER, $urandom);
        check_all_tx();
        readback(r, radio_pkg::RB_USER);
      end
    end

    // Time load and count
    readback(0, radio_pkg::RB_TIME);
    set_write(1, radio_pkg::SR_TIME_HI, $urandom);
    set_write(2, radio_pkg::SR_TIME_LO, 32'hffff_fff8);
    set_write(0, radio_pkg::SR_TIME_CTRL, 32'h1);
    repeat (4) begin
      rx_burst($urandom_range(1, 12));
      readback($urandom_range(0, 2), radio_pkg::RB_TIME);
    end

    // PPS timed load
    set_write(0, radio_pkg::SR_TIME_HI, $urandom);
    set_write(0, radio_pkg::SR_TIME_LO, $urandom);
    set_write(1, radio_pkg::SR_TIME_CTRL, 32'h2);
    rx_burst(4);
    pulse_pps();
    readback(1, radio_pkg::RB_TIME_LASTPPS);
    rx_burst(5);
    readback(2, radio_pkg::RB_TIME);
    readback(0, radio_pkg::RB_TIME_LASTPPS);

    // Receive capture
    rx_burst(6);
    for (int r = 0; r < NUM_RADIOS; r++) begin
      readback(r, radio_pkg::RB_RX_SAMPLE);
    end
    readback(1, 8'h7e);

    arbitration_test();

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: verilog/radio_block.sv
// Radio block top level
// Timekeeper, radio channels and the response arbiter
`timescale 1ns/1ps

module radio_block #(
  parameter int NUM_RADIOS = 2
) (
  input  logic                                      clk,
  input  logic                                      i_reset,
  // Settings bus
  input  logic                                      i_set_stb,
  input  logic [2:0]                                i_set_radio,
  input  logic [7:0]                                i_set_addr,
  input  logic [31:0]                               i_set_data,
  // Radio front end
  input  logic [NUM_RADIOS*radio_pkg::SAMPLE_W-1:0] i_rx,
  input  logic                                      i_rx_stb,
  output logic [NUM_RADIOS*radio_pkg::SAMPLE_W-1:0] o_tx,
  input  logic                                      i_pps,
  // Response stream
  output logic [radio_pkg::RESP_W-1:0]              o_resp_tdata,
  output logic                                      o_resp_tlast,
  output logic                                      o_resp_tvalid,
  input  logic                                      i_resp_tready
);

  localparam int SW = radio_pkg::SAMPLE_W;
  localparam int RW = radio_pkg::RESP_W;

  logic [radio_pkg::TIME_W-1:0] sample_time;
  logic [radio_pkg::TIME_W-1:0] lastpps_time;
  logic [NUM_RADIOS*RW-1:0]     resp_tdata;
  logic [NUM_RADIOS-1:0]        resp_tlast;
  logic [NUM_RADIOS-1:0]        resp_tvalid;
  logic [NUM_RADIOS-1:0]        resp_tready;

  //////////////////////////////
  // Shared timebase
  //////////////////////////////
  timekeeper u_timekeeper (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_pps          (i_pps),
    .i_rx_stb       (i_rx_stb),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .o_time         (sample_time),
    .o_lastpps_time (lastpps_time)
  );

  //////////////////////////////
  // Radio channels
  //////////////////////////////
  for (genvar i = 0; i < NUM_RADIOS; i++) begin : g_radio
    radio_channel #(
      .RADIO_NUM (i)
    ) u_radio (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_set_stb      (i_set_stb),
      .i_set_radio    (i_set_radio),
      .i_set_addr     (i_set_addr),
      .i_set_data     (i_set_data),
      .i_rx           (i_rx[SW*i +: SW]),
      .i_rx_stb       (i_rx_stb),
      .i_time         (sample_time),
      .i_lastpps_time (lastpps_time),
      .i_resp_tready  (resp_tready[i]),
      .o_tx           (o_tx[SW*i +: SW]),
      .o_resp_tdata   (resp_tdata[RW*i +: RW]),
      .o_resp_tlast   (resp_tlast[i]),
      .o_resp_tvalid  (resp_tvalid[i])
    );
  end

  // Response packet merge
  resp_arbiter #(
    .NUM_RADIOS (NUM_RADIOS)
  ) u_resp_arbiter (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_tdata  (resp_tdata),
    .i_tlast  (resp_tlast),
    .i_tvalid (resp_tvalid),
    .o_tready (resp_tready),
    .o_tdata  (o_resp_tdata),
    .o_tlast  (o_resp_tlast),
    .o_tvalid (o_resp_tvalid),
    .i_tready (i_resp_tready)
  );

endmodule

// File: verilog/resp_arbiter.sv
// Round-robin packet arbiter for the channel response streams
// Grant locks on the first beat and is released after the tlast beat
`timescale 1ns/1ps

module resp_arbiter #(
  parameter int NUM_RADIOS = 2
) (
  input  logic                                    clk,
  input  logic                                    i_reset,
  input  logic [NUM_RADIOS*radio_pkg::RESP_W-1:0] i_tdata,
  input  logic [NUM_RADIOS-1:0]                   i_tlast,
  input  logic [NUM_RADIOS-1:0]                   i_tvalid,
  output logic [NUM_RADIOS-1:0]                   o_tready,
  output logic [radio_pkg::RESP_W-1:0]            o_tdata,
  output logic                                    o_tlast,
  output logic                                    o_tvalid,
  input  logic                                    i_tready
);

  localparam int IDX_W = (NUM_RADIOS > 1) ? $clog2(NUM_RADIOS) : 1;

  // Current grant while locked, last winner otherwise
  logic [IDX_W-1:0] grant;
  logic [IDX_W-1:0] sel;
  logic             locked;

  // Search starts one past the last winner
  always_comb begin
    int   idx;
    logic found;
    sel   = grant;
    found = 1'b0;
    idx   = 0;
    if (!locked) begin
      for (int k = 1; k <= NUM_RADIOS; k++) begin
        idx = int'(grant) + k;
        if (idx >= NUM_RADIOS) begin
          idx = idx - NUM_RADIOS;
        end
        if (!found && i_tvalid[idx]) begin
          sel   = IDX_W'(idx);
          found = 1'b1;
        end
      end
    end
  end

  // Combinational path from the selected input
  assign o_tvalid = i_tvalid[sel];
  assign o_tlast  = i_tlast[sel];
  assign o_tdata  = i_tdata[sel*radio_pkg::RESP_W +: radio_pkg::RESP_W];

  always_comb begin
    o_tready      = '0;
    o_tready[sel] = i_tready;
  end

  // Lock as soon as a beat is offered so the output stays steady under back-pressure
  always_ff @(posedge clk) begin
    if (i_reset) begin
      locked <= 1'b0;
      grant  <= IDX_W'(NUM_RADIOS - 1);
    end else if (o_tvalid) begin
      grant  <= sel;
      locked <= !(i_tready && o_tlast);
    end
  end

endmodule

// File: verilog/radio_channel.sv
// One radio channel with settings registers, receive capture and transmit word
// Readback request handling and two word response packet
`timescale 1ns/1ps

module radio_channel #(
  parameter int RADIO_NUM = 0
) (
  input  logic                           clk,
  input  logic                           i_reset,
  input  logic                           i_set_stb,
  input  logic [2:0]                     i_set_radio,
  input  logic [7:0]                     i_set_addr,
  input  logic [31:0]                    i_set_data,
  input  logic [radio_pkg::SAMPLE_W-1:0] i_rx,
  input  logic                           i_rx_stb,
  input  logic [radio_pkg::TIME_W-1:0]   i_time,
  input  logic [radio_pkg::TIME_W-1:0]   i_lastpps_time,
  input  logic                           i_resp_tready,
  output logic [radio_pkg::SAMPLE_W-1:0] o_tx,
  output logic [radio_pkg::RESP_W-1:0]   o_resp_tdata,
  output logic                           o_resp_tlast,
  output logic                           o_resp_tvalid
);

  // Packet FSM states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_HDR  = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0]                     state;
  logic                           set_hit;
  logic                           rb_req;
  logic                           beat_done;
  logic [radio_pkg::SAMPLE_W-1:0] user_reg;
  logic [radio_pkg::SAMPLE_W-1:0] rx_sample;
  logic [radio_pkg::RESP_W-1:0]   rb_value;
  logic [radio_pkg::RESP_W-1:0]   rb_data;
  logic [7:0]                     rb_sel;
  logic [31:0]                    req_time;
  logic [15:0]                    seqnum;
  radio_pkg::resp_word_t          resp_word;

  //////////////////////////////
  // Settings registers
  //////////////////////////////
  assign set_hit = i_set_stb && (i_set_radio == 3'(RADIO_NUM));

  // New requests only while no packet is pending
  assign rb_req = set_hit && (i_set_addr == radio_pkg::SR_RB_REQ) && (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_tx     <= '0;
      user_reg <= '0;
    end else if (set_hit) begin
      if (i_set_addr == radio_pkg::SR_TX_WORD) begin
        o_tx <= i_set_data;
      end
      if (i_set_addr == radio_pkg::SR_USER) begin
        user_reg <= i_set_data;
      end
    end
  end

  // Receive sample capture
  always_ff @(posedge clk) begin
    if (i_reset) begin
      rx_sample <= '0;
    end else if (i_rx_stb) begin
      rx_sample <= i_rx;
    end
  end

  //////////////////////////////
  // Readback
  //////////////////////////////
  always_comb begin
    case (i_set_data[7:0])
      radio_pkg::RB_TIME:         rb_value = i_time;
      radio_pkg::RB_TIME_LASTPPS: rb_value = i_lastpps_time;
      radio_pkg::RB_RX_SAMPLE:    rb_value = {32'd0, rx_sample};
      radio_pkg::RB_USER:         rb_value = {32'd0, user_reg};
      default:                    rb_value = '0;
    endcase
  end

  // Value and time frozen on the request cycle
  always_ff @(posedge clk) begin
    if (rb_req) begin
      rb_sel   <= i_set_data[7:0];
      rb_data  <= rb_value;
      req_time <= i_time[31:0];
    end
  end

  // Header word or data word
  always_comb begin
    resp_word = '0;
    if (state == ST_HDR) begin
      resp_word.hdr.seqnum  = seqnum;
      resp_word.hdr.radio   = 8'(RADIO_NUM);
      resp_word.hdr.rb_sel  = rb_sel;
      resp_word.hdr.time_lo = req_time;
    end else begin
      resp_word.data = rb_data;
    end
  end

  assign o_resp_tdata  = resp_word;
  assign o_resp_tvalid = (state != ST_IDLE);
  assign o_resp_tlast  = (state == ST_DATA);
  assign beat_done     = o_resp_tvalid && i_resp_tready;

  // Packet FSM and the count of sent packets
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state  <= ST_IDLE;
      seqnum <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rb_req) begin
            state <= ST_HDR;
          end
        end
        ST_HDR: begin
          if (beat_done) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (beat_done) begin
            state  <= ST_IDLE;
            seqnum <= seqnum + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: verilog/timekeeper.sv
// Sample time counter driven by the radio strobe
// Settings bus load, load at next PPS and PPS time latch
`timescale 1ns/1ps

module timekeeper (
  input  logic                         clk,
  input  logic                         i_reset,
  input  logic                         i_pps,
  input  logic                         i_rx_stb,
  input  logic                         i_set_stb,
  input  logic [7:0]                   i_set_addr,
  input  logic [31:0]                  i_set_data,
  output logic [radio_pkg::TIME_W-1:0] o_time,
  output logic [radio_pkg::TIME_W-1:0] o_lastpps_time
);

  logic [31:0] time_hi;
  logic [31:0] time_lo;
  logic        wr_hi;
  logic        wr_lo;
  logic        wr_ctrl;
  logic        load_now;
  logic        load_pps;
  logic        pps_d;
  logic        pps_edge;
  logic        pps_armed;

  // Address decode for any radio number
  assign wr_hi   = i_set_stb && (i_set_addr == radio_pkg::SR_TIME_HI);
  assign wr_lo   = i_set_stb && (i_set_addr == radio_pkg::SR_TIME_LO);
  assign wr_ctrl = i_set_stb && (i_set_addr == radio_pkg::SR_TIME_CTRL);

  assign load_now = wr_ctrl && i_set_data[radio_pkg::TIME_CTRL_NOW];
  assign pps_edge = i_pps && !pps_d;
  assign load_pps = pps_edge && pps_armed;

  // Staged load value
  always_ff @(posedge clk) begin
    if (wr_hi) begin
      time_hi <= i_set_data;
    end
    if (wr_lo) begin
      time_lo <= i_set_data;
    end
  end

  // PPS edge detect and load arming
  always_ff @(posedge clk) begin
    if (i_reset) begin
      pps_d     <= 1'b0;
      pps_armed <= 1'b0;
    end else begin
      pps_d <= i_pps;
      if (load_pps) begin
        pps_armed <= 1'b0;
      end
      // A new control word overrides a pending arm
      if (wr_ctrl) begin
        pps_armed <= i_set_data[radio_pkg::TIME_CTRL_PPS];
      end
    end
  end

  // Time counter where a load beats an increment
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_time <= '0;
    end else if (load_now || load_pps) begin
      o_time <= {time_hi, time_lo};
    end else if (i_rx_stb) begin
      o_time <= o_time + 1'b1;
    end
  end

  // Time seen at the PPS edge before any load
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_lastpps_time <= '0;
    end else if (pps_edge) begin
      o_lastpps_time <= o_time;
    end
  end

endmodule

// File: verilog/radio_pkg.sv
// Register map, widths and readback selectors of the radio block
// Response word union shared by the channels and the testbench
package radio_pkg;

  // Data path widths
  localparam int SAMPLE_W = 32;
  localparam int TIME_W   = 64;
  localparam int RESP_W   = 64;

  //////////////////////////////
  // Settings bus register map
  //////////////////////////////
  localparam logic [7:0] SR_BASE = 8'd128;

  // Timekeeper
  localparam logic [7:0] SR_TIME_HI   = SR_BASE + 8'd0;
  localparam logic [7:0] SR_TIME_LO   = SR_BASE + 8'd1;
  localparam logic [7:0] SR_TIME_CTRL = SR_BASE + 8'd2;

  // Bits of the time control word
  localparam int TIME_CTRL_NOW = 0;
  localparam int TIME_CTRL_PPS = 1;

  // Per radio registers
  localparam logic [7:0] SR_TX_WORD = SR_BASE + 8'd8;
  localparam logic [7:0] SR_USER    = SR_BASE + 8'd9;
  localparam logic [7:0] SR_RB_REQ  = SR_BASE + 8'd10;

  //////////////////////////////
  // Readback selectors
  //////////////////////////////
  localparam logic [7:0] RB_TIME         = 8'd0;
  localparam logic [7:0] RB_TIME_LASTPPS = 8'd1;
  localparam logic [7:0] RB_RX_SAMPLE    = 8'd2;
  localparam logic [7:0] RB_USER         = 8'd3;

  // Header as first word of a packet and raw readback data as second word
  typedef union packed {
    struct packed {
      logic [15:0] seqnum;
      logic [7:0]  radio;
      logic [7:0]  rb_sel;
      logic [31:0] time_lo;
    } hdr;
    logic [RESP_W-1:0] data;
  } resp_word_t;

endpackage
